/* src/ntm_arith_pkg.sv */
// Arithmetic package with the default operand sizes and the modular adder phase encoding

`default_nettype none

package ntm_arith_pkg;

  ////////////////////////////////////////////////////////////
  // Default sizes
  ////////////////////////////////////////////////////////////

  // Operand and modulus width
  localparam int DEFAULT_DATA_SIZE = 32;

  // Width of the length input and of the operand index
  // Limits a run to 2**8 - 1 operands with the default
  localparam int DEFAULT_INDEX_SIZE = 8;

  ////////////////////////////////////////////////////////////
  // Modular adder phases
  ////////////////////////////////////////////////////////////

  // Phase of the two-step adder
  // Idle waits for a start
  // Add forms the wide sum
  // Reduce subtracts the modulus once when needed
  typedef enum logic [1:0] {
    ADDER_IDLE   = 2'd0,
    ADDER_ADD    = 2'd1,
    ADDER_REDUCE = 2'd2
  } adder_phase_t;

endpackage : ntm_arith_pkg

`default_nettype wire

/* src/ntm_ctrl_pkg.sv */
// Control package with the summation states and the control groups passed between blocks

`default_nettype none

package ntm_ctrl_pkg;

  ////////////////////////////////////////////////////////////
  // Summation sequencer
  ////////////////////////////////////////////////////////////

  // Top-level sequencing of one run
  // Idle waits for START, input waits for a strobe,
  // wait holds while the adder works
  typedef enum logic [1:0] {
    SUM_IDLE  = 2'd0,
    SUM_INPUT = 2'd1,
    SUM_WAIT  = 2'd2
  } summation_state_t;

  ////////////////////////////////////////////////////////////
  // Control groups
  ////////////////////////////////////////////////////////////

  // Sequencer to element counter
  // clear loads the length and zeroes the index
  // advance steps the index after a non-last result
  typedef struct packed {
    logic clear;
    logic advance;
  } count_ctrl_t;

  // Sequencer to modular adder
  // One-cycle start with the operands valid in the same cycle
  typedef struct packed {
    logic start;
  } adder_ctrl_t;

endpackage : ntm_ctrl_pkg

`default_nettype wire

/* src/ntm_element_counter.sv */
// Element counter that latches the run length, counts accepted operands and flags the last one

`timescale 1ns/1ps
`default_nettype none

module ntm_element_counter
  import ntm_ctrl_pkg::*;
#(
  parameter int INDEX_SIZE = 8
) (
  // Global
  input  wire                   CLK,
  input  wire                   RST,

  // Control from the sequencer
  input  count_ctrl_t           count_ctrl,
  input  wire  [INDEX_SIZE-1:0] LENGTH_IN,

  // Index has reached the final operand
  output logic                  last
);

  // Length of the current run and index of the operand in flight
  logic [INDEX_SIZE-1:0] length_q;
  logic [INDEX_SIZE-1:0] index_q;
  logic [INDEX_SIZE-1:0] last_index;

  // Length of at least one assumed
  assign last_index = length_q - 1'b1;
  assign last       = (index_q == last_index);

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      length_q <= '0;
      index_q  <= '0;
    end else if (count_ctrl.clear) begin
      // New run
      length_q <= LENGTH_IN;
      index_q  <= '0;
    end else if (count_ctrl.advance) begin
      index_q <= index_q + 1'b1;
    end
  end

endmodule : ntm_element_counter

`default_nettype wire

/* src/ntm_modular_adder.sv */
// Modular adder doing a wide addition and then one conditional subtraction of the modulus

`timescale 1ns/1ps
`default_nettype none

module ntm_modular_adder
  import ntm_arith_pkg::*;
  import ntm_ctrl_pkg::*;
#(
  parameter int DATA_SIZE = 32
) (
  // Global
  input  wire                   CLK,
  input  wire                   RST,

  // Control
  input  adder_ctrl_t           adder_ctrl,
  output logic                  done,

  // Data, both operands below the modulus
  input  wire  [DATA_SIZE-1:0]  operand_a,
  input  wire  [DATA_SIZE-1:0]  operand_b,
  input  wire  [DATA_SIZE-1:0]  modulus,
  output logic [DATA_SIZE-1:0]  result
);

  ////////////////////////////////////////////////////////////
  // Signals
  ////////////////////////////////////////////////////////////

  // Registered phase and the phase acting in this cycle
  adder_phase_t phase_q;
  adder_phase_t phase;

  // One extra bit keeps the carry of a + b
  logic [DATA_SIZE:0]   sum_q;
  logic [DATA_SIZE:0]   sum_minus_mod;
  logic                 sum_ge_mod;
  logic [DATA_SIZE-1:0] reduced;

  // Start itself is the add cycle
  assign phase = adder_ctrl.start ? ADDER_ADD : phase_q;

  ////////////////////////////////////////////////////////////
  // Reduction
  ////////////////////////////////////////////////////////////

  // a + b < 2 * modulus, so a single subtraction suffices
  assign sum_ge_mod    = (sum_q >= {1'b0, modulus});
  assign sum_minus_mod = sum_q - {1'b0, modulus};

  // Upper bit is zero after reduction
  assign reduced = sum_ge_mod ? sum_minus_mod[DATA_SIZE-1:0] : sum_q[DATA_SIZE-1:0];

  ////////////////////////////////////////////////////////////
  // Phase sequencing
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      phase_q <= ADDER_IDLE;
      done    <= 1'b0;
    end else begin
      done <= 1'b0;
      case (phase)
        ADDER_ADD: begin
          phase_q <= ADDER_REDUCE;
        end
        ADDER_REDUCE: begin
          // Result valid together with done
          phase_q <= ADDER_IDLE;
          done    <= 1'b1;
        end
        default: begin
          phase_q <= ADDER_IDLE;
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////////////////////////

  // Result holds until the next reduce phase
  always_ff @(posedge CLK) begin
    case (phase)
      ADDER_ADD: begin
        sum_q <= {1'b0, operand_a} + {1'b0, operand_b};
      end
      ADDER_REDUCE: begin
        result <= reduced;
      end
      default: begin
        sum_q <= sum_q;
      end
    endcase
  end

endmodule : ntm_modular_adder

`default_nettype wire

/* src/ntm_summation_fsm.sv */
// Summation sequencer that accepts operands, keeps the running total and drives the outputs

`timescale 1ns/1ps
`default_nettype none

module ntm_summation_fsm
  import ntm_ctrl_pkg::*;
#(
  parameter int DATA_SIZE = 32
) (
  // Global
  input  wire                   CLK,
  input  wire                   RST,

  // Outside control
  input  wire                   START,
  output logic                  READY,
  input  wire                   DATA_IN_ENABLE,
  output logic                  DATA_OUT_ENABLE,

  // Outside data
  input  wire  [DATA_SIZE-1:0]  DATA_IN,
  input  wire  [DATA_SIZE-1:0]  MODULO_IN,
  output logic [DATA_SIZE-1:0]  DATA_OUT,

  // Element counter
  output count_ctrl_t           count_ctrl,
  input  wire                   last,

  // Modular adder
  output adder_ctrl_t           adder_ctrl,
  output logic [DATA_SIZE-1:0]  operand_a,
  output logic [DATA_SIZE-1:0]  operand_b,
  output logic [DATA_SIZE-1:0]  modulus,
  input  wire                   adder_done,
  input  wire  [DATA_SIZE-1:0]  adder_result
);

  ////////////////////////////////////////////////////////////
  // Signals
  ////////////////////////////////////////////////////////////

  summation_state_t state;

  // Accepted events
  logic start_accept;
  logic operand_load;
  logic result_return;

  // START only counts in idle and strobes only in input
  assign start_accept  = (state == SUM_IDLE) && START;
  assign operand_load  = (state == SUM_INPUT) && DATA_IN_ENABLE;
  assign result_return = (state == SUM_WAIT) && adder_done;

  ////////////////////////////////////////////////////////////
  // Counter control
  ////////////////////////////////////////////////////////////

  // Same-cycle pulses latch the length with START
  always_comb begin
    count_ctrl         = '0;
    count_ctrl.clear   = start_accept;
    // Index only moves when another operand follows
    count_ctrl.advance = result_return && !last;
  end

  ////////////////////////////////////////////////////////////
  // State, outputs and running total
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state           <= SUM_IDLE;
      READY           <= 1'b0;
      DATA_OUT_ENABLE <= 1'b0;
      DATA_OUT        <= '0;
      adder_ctrl      <= '0;
    end else begin
      // Pulses by default
      READY           <= 1'b0;
      DATA_OUT_ENABLE <= 1'b0;
      adder_ctrl      <= '0;

      case (state)
        SUM_IDLE: begin
          if (start_accept) begin
            // Total restarts from zero
            DATA_OUT <= '0;
            state    <= SUM_INPUT;
          end
        end
        SUM_INPUT: begin
          if (operand_load) begin
            // Adder sees start one cycle after the strobe
            adder_ctrl.start <= 1'b1;
            state            <= SUM_WAIT;
          end
        end
        SUM_WAIT: begin
          if (result_return) begin
            DATA_OUT        <= adder_result;
            DATA_OUT_ENABLE <= 1'b1;
            if (last) begin
              // Back to idle in the same cycle as the final pulse
              READY <= 1'b1;
              state <= SUM_IDLE;
            end else begin
              state <= SUM_INPUT;
            end
          end
        end
        default: begin
          state <= SUM_IDLE;
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Adder operands
  ////////////////////////////////////////////////////////////

  // Captured on the strobe and held through the adder's phases
  // Operand B is the total so far
  always_ff @(posedge CLK) begin
    if (operand_load) begin
      operand_a <= DATA_IN;
      operand_b <= DATA_OUT;
      modulus   <= MODULO_IN;
    end
  end

endmodule : ntm_summation_fsm

`default_nettype wire

/* src/ntm_scalar_summation.sv */
// Scalar summation top level joining sequencer, element counter and modular adder

`timescale 1ns/1ps
`default_nettype none

module ntm_scalar_summation
  import ntm_arith_pkg::*;
  import ntm_ctrl_pkg::*;
#(
  parameter int DATA_SIZE  = DEFAULT_DATA_SIZE,
  parameter int INDEX_SIZE = DEFAULT_INDEX_SIZE
) (
  // Global
  input  wire                   CLK,
  input  wire                   RST,

  // Control
  input  wire                   START,
  output logic                  READY,
  input  wire                   DATA_IN_ENABLE,
  output logic                  DATA_OUT_ENABLE,

  // Data
  input  wire  [DATA_SIZE-1:0]  MODULO_IN,
  input  wire  [INDEX_SIZE-1:0] LENGTH_IN,
  input  wire  [DATA_SIZE-1:0]  DATA_IN,
  output logic [DATA_SIZE-1:0]  DATA_OUT
);

  ////////////////////////////////////////////////////////////
  // Internal wiring
  ////////////////////////////////////////////////////////////

  // Sequencer and counter
  count_ctrl_t          count_ctrl;
  logic                 last;

  // Sequencer and adder
  adder_ctrl_t          adder_ctrl;
  logic [DATA_SIZE-1:0] operand_a;
  logic [DATA_SIZE-1:0] operand_b;
  logic [DATA_SIZE-1:0] modulus;
  logic                 adder_done;
  logic [DATA_SIZE-1:0] adder_result;

  ////////////////////////////////////////////////////////////
  // Sequencer
  ////////////////////////////////////////////////////////////

  ntm_summation_fsm #(
    .DATA_SIZE (DATA_SIZE)
  ) ntm_summation_fsm_inst (
    .CLK             (CLK),
    .RST             (RST),
    .START           (START),
    .READY           (READY),
    .DATA_IN_ENABLE  (DATA_IN_ENABLE),
    .DATA_OUT_ENABLE (DATA_OUT_ENABLE),
    .DATA_IN         (DATA_IN),
    .MODULO_IN       (MODULO_IN),
    .DATA_OUT        (DATA_OUT),
    .count_ctrl      (count_ctrl),
    .last            (last),
    .adder_ctrl      (adder_ctrl),
    .operand_a       (operand_a),
    .operand_b       (operand_b),
    .modulus         (modulus),
    .adder_done      (adder_done),
    .adder_result    (adder_result)
  );

  // Length latched here, not in the sequencer
  ntm_element_counter #(
    .INDEX_SIZE (INDEX_SIZE)
  ) ntm_element_counter_inst (
    .CLK        (CLK),
    .RST        (RST),
    .count_ctrl (count_ctrl),
    .LENGTH_IN  (LENGTH_IN),
    .last       (last)
  );

  // Steps through ADDER_ADD and ADDER_REDUCE, done two cycles after start
  ntm_modular_adder #(
    .DATA_SIZE (DATA_SIZE)
  ) ntm_modular_adder_inst (
    .CLK        (CLK),
    .RST        (RST),
    .adder_ctrl (adder_ctrl),
    .done       (adder_done),
    .operand_a  (operand_a),
    .operand_b  (operand_b),
    .modulus    (modulus),
    .result     (adder_result)
  );

endmodule : ntm_scalar_summation

`default_nettype wire

/* verification/ntm_summation_model.svh */
// Summation reference model with the expected running total and random operand helpers
`ifndef NTM_SUMMATION_MODEL_SVH
`define NTM_SUMMATION_MODEL_SVH

// Expected total of the run in progress
logic [DATA_SIZE-1:0] model_total;

task automatic clear_total();
  model_total = '0;
endtask

// Add and take the modulus off once if the sum reached it
task automatic add_to_total(input logic [DATA_SIZE-1:0] operand,
                            input logic [DATA_SIZE-1:0] modulus);
  longint unsigned sum;
  sum = model_total;
  sum += operand;
  if (sum >= modulus)
    sum -= modulus;
  model_total = DATA_SIZE'(sum);
endtask

// Nonzero modulus of at least floor
function automatic logic [DATA_SIZE-1:0] random_modulus(input int unsigned floor);
  logic [DATA_SIZE-1:0] value;
  value = DATA_SIZE'($urandom);
  if (value < floor)
    value = DATA_SIZE'(floor);
  return value;
endfunction

function automatic logic [DATA_SIZE-1:0] operand_below(input logic [DATA_SIZE-1:0] modulus);
  return DATA_SIZE'($urandom) % modulus;
endfunction

// One to four below the modulus
function automatic logic [DATA_SIZE-1:0] operand_near(input logic [DATA_SIZE-1:0] modulus);
  return modulus - DATA_SIZE'(1 + $urandom % 4);
endfunction

`endif

/* verification/ntm_scalar_summation_tb.sv */
// Scalar summation testbench checking random modular sums against a reference model

`timescale 1ns/1ps
`default_nettype none

module ntm_scalar_summation_tb
  import ntm_arith_pkg::*;
  import ntm_ctrl_pkg::*;
();

  localparam int DATA_SIZE  = DEFAULT_DATA_SIZE;
  localparam int INDEX_SIZE = DEFAULT_INDEX_SIZE;
  // Falling edges from driving a strobe to seeing its output pulse
  localparam int RESULT_LATENCY = 4;
  localparam int WAIT_LIMIT     = 20;

  logic                  CLK;
  logic                  RST;
  logic                  START;
  logic                  READY;
  logic                  DATA_IN_ENABLE;
  logic                  DATA_OUT_ENABLE;
  logic [DATA_SIZE-1:0]  MODULO_IN;
  logic [INDEX_SIZE-1:0] LENGTH_IN;
  logic [DATA_SIZE-1:0]  DATA_IN;
  logic [DATA_SIZE-1:0]  DATA_OUT;

  int errors;
  int tests_run;
  int tests_failed;
  bit timed_out;

  `include "ntm_summation_model.svh"

  ntm_scalar_summation #(
    .DATA_SIZE  (DATA_SIZE),
    .INDEX_SIZE (INDEX_SIZE)
  ) ntm_scalar_summation_inst (
    .CLK             (CLK),
    .RST             (RST),
    .START           (START),
    .READY           (READY),
    .DATA_IN_ENABLE  (DATA_IN_ENABLE),
    .DATA_OUT_ENABLE (DATA_OUT_ENABLE),
    .MODULO_IN       (MODULO_IN),
    .LENGTH_IN       (LENGTH_IN),
    .DATA_IN         (DATA_IN),
    .DATA_OUT        (DATA_OUT)
  );

  always #5 CLK = ~CLK;

  ////////////////////////////////////////////////////////////
  // Reporting
  ////////////////////////////////////////////////////////////

  task automatic report_value(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
    errors++;
    $display("FAIL %s expected %0d actual %0d", name, expected, actual);
  endtask

  task automatic finish_test(input string name, input int mark);
    tests_run++;
    if (errors == mark) begin
      $display("test %s: passed", name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d mismatches", name, errors - mark);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus tasks called on a falling edge
  ////////////////////////////////////////////////////////////

  task automatic pulse_start(input int length);
    LENGTH_IN = INDEX_SIZE'(length);
    START     = 1'b1;
    @(negedge CLK);
    START     = 1'b0;
  endtask

  task automatic send_operand(input logic [DATA_SIZE-1:0] value,
                              input logic [DATA_SIZE-1:0] modulus);
    DATA_IN        = value;
    MODULO_IN      = modulus;
    DATA_IN_ENABLE = 1'b1;
    @(negedge CLK);
    DATA_IN_ENABLE = 1'b0;
  endtask

  // Waits for the next output pulse and counts the falling edges passed
  task automatic wait_output(input string name, output int cycles);
    summation_state_t fsm_state;
    cycles = 0;
    while (!timed_out && cycles < WAIT_LIMIT) begin
      @(negedge CLK);
      cycles++;
      if (DATA_OUT_ENABLE)
        break;
      if (READY) begin
        errors++;
        $display("%s: READY pulsed without DATA_OUT_ENABLE", name);
      end
    end
    if (!timed_out && !DATA_OUT_ENABLE) begin
      fsm_state = ntm_scalar_summation_inst.ntm_summation_fsm_inst.state;
      timed_out = 1'b1;
      errors++;
      $display("%s: timeout, no DATA_OUT_ENABLE within %0d cycles, sequencer in %s",
               name, cycles, fsm_state.name());
    end
  endtask

  // One run that returns on the falling edge showing READY
  task automatic run_sequence(input string name, input int length,
                              input logic [DATA_SIZE-1:0] modulus,
                              input bit near_top, input bit noisy);
    logic [DATA_SIZE-1:0] operand;
    int cycles;
    int latency;
    clear_total();
    pulse_start(length);
    for (int i = 0; i < length && !timed_out; i++) begin
      operand = near_top ? operand_near(modulus) : operand_below(modulus);
      send_operand(operand, modulus);
      add_to_total(operand, modulus);
      latency = 1;
      if (noisy) begin
        // Strobe and START while the adder is busy
        DATA_IN        = ~operand;
        LENGTH_IN      = '1;
        DATA_IN_ENABLE = 1'b1;
        START          = 1'b1;
        @(negedge CLK);
        DATA_IN_ENABLE = 1'b0;
        START          = 1'b0;
        latency++;
      end
      wait_output(name, cycles);
      latency += cycles;
      if (!timed_out) begin
        if (DATA_OUT !== model_total)
          report_value(name, model_total, DATA_OUT);
        if (DATA_OUT >= modulus) begin
          errors++;
          $display("%s: DATA_OUT %0d is not below modulus %0d", name, DATA_OUT, modulus);
        end
        if (READY !== (i == length - 1)) begin
          errors++;
          $display("%s: READY wrong on result %0d of %0d", name, i + 1, length);
        end
        if (latency != RESULT_LATENCY)
          report_value({name, " latency"}, RESULT_LATENCY, latency);
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    int mark;
    int cycles;
    logic [DATA_SIZE-1:0] modulus;
    logic [DATA_SIZE-1:0] operand;
    void'($urandom(32'h519b3e97));
    CLK            = 1'b0;
    RST            = 1'b1;
    START          = 1'b0;
    DATA_IN_ENABLE = 1'b0;
    MODULO_IN      = '0;
    LENGTH_IN      = '0;
    DATA_IN        = '0;
    errors         = 0;
    tests_run      = 0;
    tests_failed   = 0;
    timed_out      = 1'b0;
    repeat (5) @(posedge CLK);
    @(negedge CLK);
    RST = 1'b0;

    mark = errors;
    @(negedge CLK);
    if (READY !== 1'b0)
      report_value("reset_state READY", 0, READY);
    if (DATA_OUT_ENABLE !== 1'b0)
      report_value("reset_state DATA_OUT_ENABLE", 0, DATA_OUT_ENABLE);
    if (DATA_OUT !== '0)
      report_value("reset_state DATA_OUT", 0, DATA_OUT);
    finish_test("reset_state", mark);

    // Expected total is the operand itself
    mark    = errors;
    modulus = random_modulus(2);
    operand = operand_below(modulus);
    pulse_start(1);
    send_operand(operand, modulus);
    wait_output("single_operand", cycles);
    if (!timed_out) begin
      if (DATA_OUT !== operand)
        report_value("single_operand DATA_OUT", operand, DATA_OUT);
      if (READY !== 1'b1) begin
        errors++;
        $display("single_operand: READY missing with the only result");
      end
      if (cycles + 1 != RESULT_LATENCY)
        report_value("single_operand latency", RESULT_LATENCY, cycles + 1);
    end
    finish_test("single_operand", mark);

    mark = errors;
    for (int run = 0; run < 50 && !timed_out; run++)
      run_sequence("random_sums", 1 + $urandom % 8, random_modulus(1), 1'b0, 1'b0);
    finish_test("random_sums", mark);

    // Large operands make the total wrap on every step after the first
    mark = errors;
    for (int run = 0; run < 10 && !timed_out; run++)
      run_sequence("modular_wrap", 2 + $urandom % 7, random_modulus(64), 1'b1, 1'b0);
    finish_test("modular_wrap", mark);

    mark = errors;
    for (int run = 0; run < 5 && !timed_out; run++)
      run_sequence("ignored_inputs", 1 + $urandom % 8, random_modulus(1), 1'b0, 1'b1);
    // No stray pulse once the last run has ended
    repeat (6) begin
      @(negedge CLK);
      if (DATA_OUT_ENABLE || READY) begin
        errors++;
        $display("ignored_inputs: output pulse after the run ended");
      end
    end
    finish_test("ignored_inputs", mark);

    // Second and third START land in the READY cycle of the run before
    mark = errors;
    run_sequence("back_to_back", 3, random_modulus(1), 1'b0, 1'b0);
    run_sequence("back_to_back", 2, random_modulus(1), 1'b0, 1'b0);
    run_sequence("back_to_back", 1, random_modulus(1), 1'b0, 1'b0);
    finish_test("back_to_back", mark);

    $display("Tests run: %0d, tests failed: %0d, mismatches: %0d",
             tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule : ntm_scalar_summation_tb

`default_nettype wire

/* sources.f */
+incdir+verification
src/ntm_arith_pkg.sv
src/ntm_ctrl_pkg.sv
src/ntm_element_counter.sv
src/ntm_modular_adder.sv
src/ntm_summation_fsm.sv
src/ntm_scalar_summation.sv
verification/ntm_scalar_summation_tb.sv

/* Makefile */
TOP := ntm_scalar_summation_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing -Wno-fatal -f sources.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "^No errors$$"

clean:
	rm -rf obj_dir
